// ==== join_pkg.sv ====
// Request field types and opcode encoding for the stream join
// Opcode 2'd3 is not a read, so it is routed like a write
package join_pkg;

  // ------------------------------------------------------------------
  // Request fields
  // ------------------------------------------------------------------

  // Operation code of a request
  typedef logic [1:0] opcode_t;

  // Burst length, number of beats minus one
  typedef logic [7:0] len_t;

  // Stream ID carried by requests and beats
  typedef logic [3:0] tid_t;

  // ------------------------------------------------------------------
  // Opcodes
  // ------------------------------------------------------------------

  // Write, burst comes from the receive stream
  localparam opcode_t OP_WR        = 2'd0;
  // Read, burst comes from the response stream
  localparam opcode_t OP_RD        = 2'd1;
  // Atomic read, also served from the response stream
  localparam opcode_t OP_RD_ATOMIC = 2'd2;

  // True for every opcode that takes its burst from the response stream
  function automatic logic is_rd_op(input opcode_t op);
    logic rd;
    rd = (op == OP_RD) || (op == OP_RD_ATOMIC);
    return rd;
  endfunction

endpackage

// ==== req_queue.sv ====
// First-word-fall-through request queue, DEPTH a power of two and at least 2
// Holds DEPTH entries in memory plus one in the output register
`timescale 1ns/1ps

module req_queue
  import join_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic    aclk,
  input  logic    aresetn,
  // Write side
  input  logic    in_valid,
  output logic    in_ready,
  input  opcode_t in_opcode,
  input  len_t    in_len,
  input  tid_t    in_tid,
  // Read side, registered
  output logic    out_valid,
  input  logic    out_ready,
  output opcode_t out_opcode,
  output len_t    out_len,
  output tid_t    out_tid
);

  localparam int PTR_BITS   = $clog2(DEPTH);
  localparam int CNT_BITS   = PTR_BITS + 1;
  localparam int ENTRY_BITS = $bits(opcode_t) + $bits(len_t) + $bits(tid_t);

  // Packed request entries
  logic [ENTRY_BITS-1:0] mem [DEPTH];
  logic [ENTRY_BITS-1:0] in_entry;

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  // Entries held in memory, output register not counted
  logic [CNT_BITS-1:0] count;

  logic push;
  logic load;
  logic bypass;
  logic mem_wr;
  logic mem_rd;

  assign in_entry = {in_opcode, in_len, in_tid};

  // ------------------------------------------------------------------
  // Control
  // ------------------------------------------------------------------

  // Not full
  assign in_ready = (count != CNT_BITS'(DEPTH));
  assign push     = in_valid & in_ready;
  // Output register empty or being drained
  assign load     = ~out_valid | out_ready;
  // Empty memory, new request goes straight to the output register
  assign bypass   = load & (count == '0);
  assign mem_rd   = load & (count != '0);
  assign mem_wr   = push & ~bypass;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous write and read keeps the count
      if (mem_wr && !mem_rd) begin
        count <= count + 1'b1;
      end else if (mem_rd && !mem_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // Storage and output register
  // ------------------------------------------------------------------

  always_ff @(posedge aclk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= in_entry;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= mem_rd | push;
    end
  end

  // Oldest entry first, bypass only when memory is empty
  always_ff @(posedge aclk) begin
    if (mem_rd) begin
      {out_opcode, out_len, out_tid} <= mem[rd_ptr];
    end else if (bypass && push) begin
      {out_opcode, out_len, out_tid} <= in_entry;
    end
  end

endmodule

// ==== beat_fifo.sv ====
// Beat FIFO with registered output, DEPTH a power of two and at least 2
// in_tready follows out_tready when full, so the FIFO keeps one beat per cycle
`timescale 1ns/1ps

module beat_fifo
  import join_pkg::*;
#(
  parameter int DATA_BITS = 64,
  parameter int DEPTH     = 16
) (
  input  logic                   aclk,
  input  logic                   aresetn,
  // Write side
  input  logic                   in_tvalid,
  output logic                   in_tready,
  input  logic [DATA_BITS-1:0]   in_tdata,
  input  logic [DATA_BITS/8-1:0] in_tkeep,
  input  logic                   in_tlast,
  input  tid_t                   in_tid,
  // Read side, registered
  output logic                   out_tvalid,
  input  logic                   out_tready,
  output logic [DATA_BITS-1:0]   out_tdata,
  output logic [DATA_BITS/8-1:0] out_tkeep,
  output logic                   out_tlast,
  output tid_t                   out_tid
);

  localparam int KEEP_BITS  = DATA_BITS / 8;
  localparam int PTR_BITS   = $clog2(DEPTH);
  localparam int CNT_BITS   = PTR_BITS + 1;
  localparam int ENTRY_BITS = DATA_BITS + KEEP_BITS + 1 + $bits(tid_t);

  // Packed beats, tid on top and data at the bottom
  logic [ENTRY_BITS-1:0] mem [DEPTH];
  logic [ENTRY_BITS-1:0] in_entry;

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  // Beats in memory, not counting the output stage
  logic [CNT_BITS-1:0] count;

  logic full;
  logic push;
  logic load;
  logic bypass;
  logic mem_wr;
  logic mem_rd;

  assign in_entry = {in_tid, in_tlast, in_tkeep, in_tdata};

  // ------------------------------------------------------------------
  // Control
  // ------------------------------------------------------------------

  assign full   = (count == CNT_BITS'(DEPTH));
  // Output stage free or handing its beat over this cycle
  assign load   = ~out_tvalid | out_tready;
  // Full memory still takes a beat while one leaves
  assign in_tready = ~full | load;
  assign push   = in_tvalid & in_tready;
  assign bypass = load & (count == '0);
  assign mem_rd = load & (count != '0);
  assign mem_wr = push & ~bypass;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (mem_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (mem_wr && !mem_rd) begin
        count <= count + 1'b1;
      end else if (mem_rd && !mem_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // Storage and output stage
  // ------------------------------------------------------------------

  // Same slot may be written and read when full, read sees the old beat
  always_ff @(posedge aclk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= in_entry;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      out_tvalid <= 1'b0;
    end else if (load) begin
      out_tvalid <= mem_rd | push;
    end
  end

  always_ff @(posedge aclk) begin
    if (mem_rd) begin
      {out_tid, out_tlast, out_tkeep, out_tdata} <= mem[rd_ptr];
    end else if (bypass && push) begin
      {out_tid, out_tlast, out_tkeep, out_tdata} <= in_entry;
    end
  end

endmodule

// ==== stream_join.sv ====
// Join controller, one burst of len+1 beats per accepted request
// Input tlast is passed through and never compared with the length
`timescale 1ns/1ps

module stream_join
  import join_pkg::*;
#(
  parameter int DATA_BITS = 64
) (
  input  logic                   aclk,
  input  logic                   aresetn,
  // Request in
  input  logic                   rq_valid,
  output logic                   rq_ready,
  input  opcode_t                rq_opcode,
  input  len_t                   rq_len,
  input  tid_t                   rq_tid,
  // Request queue write side
  output logic                   q_valid,
  input  logic                   q_ready,
  output opcode_t                q_opcode,
  output len_t                   q_len,
  output tid_t                   q_tid,
  // Receive stream, write data
  input  logic                   recv_tvalid,
  output logic                   recv_tready,
  input  logic [DATA_BITS-1:0]   recv_tdata,
  input  logic [DATA_BITS/8-1:0] recv_tkeep,
  input  logic                   recv_tlast,
  input  tid_t                   recv_tid,
  // Response stream, read data
  input  logic                   resp_tvalid,
  output logic                   resp_tready,
  input  logic [DATA_BITS-1:0]   resp_tdata,
  input  logic [DATA_BITS/8-1:0] resp_tkeep,
  input  logic                   resp_tlast,
  input  tid_t                   resp_tid,
  // Beat FIFO write side
  output logic                   f_tvalid,
  input  logic                   f_tready,
  output logic [DATA_BITS-1:0]   f_tdata,
  output logic [DATA_BITS/8-1:0] f_tkeep,
  output logic                   f_tlast,
  output tid_t                   f_tid
);

  typedef enum logic [0:0] {
    ST_IDLE,
    ST_MUX
  } state_t;

  state_t state;
  state_t state_next;

  // Current burst from the response stream
  logic rd_sel;
  logic rd_sel_next;
  // Beats left after the current one
  len_t cnt;
  len_t cnt_next;

  logic f_hs;
  logic tr_done;

  // ------------------------------------------------------------------
  // Stream mux
  // ------------------------------------------------------------------

  // Payload always follows the selected side, valid is gated
  always_comb begin
    f_tdata  = rd_sel ? resp_tdata : recv_tdata;
    f_tkeep  = rd_sel ? resp_tkeep : recv_tkeep;
    f_tlast  = rd_sel ? resp_tlast : recv_tlast;
    f_tid    = rd_sel ? resp_tid : recv_tid;
    f_tvalid = (state == ST_MUX) & (rd_sel ? resp_tvalid : recv_tvalid);
    // Unselected side stays stalled
    recv_tready = (state == ST_MUX) & ~rd_sel & f_tready;
    resp_tready = (state == ST_MUX) & rd_sel & f_tready;
  end

  assign f_hs    = f_tvalid & f_tready;
  // Last beat of the burst taken this cycle
  assign tr_done = f_hs & (cnt == '0);

  // ------------------------------------------------------------------
  // Request acceptance
  // ------------------------------------------------------------------

  // Idle, or back to back on the final beat, and room in the queue
  assign q_valid  = rq_valid & q_ready & ((state == ST_IDLE) | tr_done);
  assign rq_ready = q_valid;
  // Request forwarded unchanged
  assign q_opcode = rq_opcode;
  assign q_len    = rq_len;
  assign q_tid    = rq_tid;

  // ------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------

  always_comb begin
    state_next  = state;
    rd_sel_next = rd_sel;
    cnt_next    = cnt;
    case (state)
      ST_IDLE: begin
        if (q_valid) begin
          state_next  = ST_MUX;
          rd_sel_next = is_rd_op(rq_opcode);
          cnt_next    = rq_len;
        end
      end
      ST_MUX: begin
        if (tr_done) begin
          if (q_valid) begin
            // Next burst starts right away
            rd_sel_next = is_rd_op(rq_opcode);
            cnt_next    = rq_len;
          end else begin
            state_next = ST_IDLE;
          end
        end else if (f_hs) begin
          cnt_next = cnt - len_t'(1);
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state  <= ST_IDLE;
      rd_sel <= 1'b0;
      cnt    <= '0;
    end else begin
      state  <= state_next;
      rd_sel <= rd_sel_next;
      cnt    <= cnt_next;
    end
  end

endmodule

// ==== join_top.sv ====
// Request-ordered join of the receive and response streams
// One burst per request, bursts never interleave, single clock domain
`timescale 1ns/1ps

module join_top
  import join_pkg::*;
#(
  parameter int DATA_BITS  = 64,
  parameter int REQ_DEPTH  = 4,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                   aclk,
  input  logic                   aresetn,
  // Request in
  input  logic                   rq_valid,
  output logic                   rq_ready,
  input  opcode_t                rq_opcode,
  input  len_t                   rq_len,
  input  tid_t                   rq_tid,
  // Request out, in acceptance order
  output logic                   sq_valid,
  input  logic                   sq_ready,
  output opcode_t                sq_opcode,
  output len_t                   sq_len,
  output tid_t                   sq_tid,
  // Receive stream
  input  logic                   recv_tvalid,
  output logic                   recv_tready,
  input  logic [DATA_BITS-1:0]   recv_tdata,
  input  logic [DATA_BITS/8-1:0] recv_tkeep,
  input  logic                   recv_tlast,
  input  tid_t                   recv_tid,
  // Response stream
  input  logic                   resp_tvalid,
  output logic                   resp_tready,
  input  logic [DATA_BITS-1:0]   resp_tdata,
  input  logic [DATA_BITS/8-1:0] resp_tkeep,
  input  logic                   resp_tlast,
  input  tid_t                   resp_tid,
  // Joined output stream
  output logic                   m_tvalid,
  input  logic                   m_tready,
  output logic [DATA_BITS-1:0]   m_tdata,
  output logic [DATA_BITS/8-1:0] m_tkeep,
  output logic                   m_tlast,
  output tid_t                   m_tid
);

  localparam int KEEP_BITS = DATA_BITS / 8;

  // Controller to request queue
  logic    q_valid;
  logic    q_ready;
  opcode_t q_opcode;
  len_t    q_len;
  tid_t    q_tid;

  // Controller to beat FIFO
  logic                 f_tvalid;
  logic                 f_tready;
  logic [DATA_BITS-1:0] f_tdata;
  logic [KEEP_BITS-1:0] f_tkeep;
  logic                 f_tlast;
  tid_t                 f_tid;

  // ------------------------------------------------------------------
  // Controller
  // ------------------------------------------------------------------

  stream_join #(
    .DATA_BITS (DATA_BITS)
  ) u_stream_join (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .rq_valid    (rq_valid),
    .rq_ready    (rq_ready),
    .rq_opcode   (rq_opcode),
    .rq_len      (rq_len),
    .rq_tid      (rq_tid),
    .q_valid     (q_valid),
    .q_ready     (q_ready),
    .q_opcode    (q_opcode),
    .q_len       (q_len),
    .q_tid       (q_tid),
    .recv_tvalid (recv_tvalid),
    .recv_tready (recv_tready),
    .recv_tdata  (recv_tdata),
    .recv_tkeep  (recv_tkeep),
    .recv_tlast  (recv_tlast),
    .recv_tid    (recv_tid),
    .resp_tvalid (resp_tvalid),
    .resp_tready (resp_tready),
    .resp_tdata  (resp_tdata),
    .resp_tkeep  (resp_tkeep),
    .resp_tlast  (resp_tlast),
    .resp_tid    (resp_tid),
    .f_tvalid    (f_tvalid),
    .f_tready    (f_tready),
    .f_tdata     (f_tdata),
    .f_tkeep     (f_tkeep),
    .f_tlast     (f_tlast),
    .f_tid       (f_tid)
  );

  // ------------------------------------------------------------------
  // Buffers
  // ------------------------------------------------------------------

  // Full queue holds off new bursts
  req_queue #(
    .DEPTH (REQ_DEPTH)
  ) u_req_queue (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .in_valid   (q_valid),
    .in_ready   (q_ready),
    .in_opcode  (q_opcode),
    .in_len     (q_len),
    .in_tid     (q_tid),
    .out_valid  (sq_valid),
    .out_ready  (sq_ready),
    .out_opcode (sq_opcode),
    .out_len    (sq_len),
    .out_tid    (sq_tid)
  );

  beat_fifo #(
    .DATA_BITS (DATA_BITS),
    .DEPTH     (FIFO_DEPTH)
  ) u_beat_fifo (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .in_tvalid  (f_tvalid),
    .in_tready  (f_tready),
    .in_tdata   (f_tdata),
    .in_tkeep   (f_tkeep),
    .in_tlast   (f_tlast),
    .in_tid     (f_tid),
    .out_tvalid (m_tvalid),
    .out_tready (m_tready),
    .out_tdata  (m_tdata),
    .out_tkeep  (m_tkeep),
    .out_tlast  (m_tlast),
    .out_tid    (m_tid)
  );

endmodule

// ==== tb_join_top.sv ====
// Random traffic for join_top checked against a request-ordered model
// Needs a simulator with concurrent assertion support
`timescale 1ns/1ps

module tb_join_top
  import join_pkg::*;
();

  localparam int DATA_BITS      = 64;
  localparam int KEEP_BITS      = DATA_BITS / 8;
  localparam int N_REQ          = 40;
  localparam int MAX_LEN        = 7;
  localparam int MAX_BEATS      = N_REQ * (MAX_LEN + 1);
  localparam int TIMEOUT_CYCLES = N_REQ * 8 * 4 + 200;
  // Stream index for the source arrays
  localparam int RECV = 0;
  localparam int RESP = 1;

  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic [KEEP_BITS-1:0] keep;
    logic                 last;
    tid_t                 tid;
  } beat_t;

  logic aclk;
  logic aresetn;

  logic    rq_valid;
  logic    rq_ready;
  opcode_t rq_opcode;
  len_t    rq_len;
  tid_t    rq_tid;
  logic    sq_valid;
  logic    sq_ready;
  opcode_t sq_opcode;
  len_t    sq_len;
  tid_t    sq_tid;

  logic                 recv_tvalid;
  logic                 recv_tready;
  logic [DATA_BITS-1:0] recv_tdata;
  logic [KEEP_BITS-1:0] recv_tkeep;
  logic                 recv_tlast;
  tid_t                 recv_tid;
  logic                 resp_tvalid;
  logic                 resp_tready;
  logic [DATA_BITS-1:0] resp_tdata;
  logic [KEEP_BITS-1:0] resp_tkeep;
  logic                 resp_tlast;
  tid_t                 resp_tid;
  logic                 m_tvalid;
  logic                 m_tready;
  logic [DATA_BITS-1:0] m_tdata;
  logic [KEEP_BITS-1:0] m_tkeep;
  logic                 m_tlast;
  tid_t                 m_tid;

  // Source side of both input streams
  beat_t src_beat  [2];
  logic  src_valid [2];
  logic  src_ready [2];

  // Reference model, request list and expected output beats
  opcode_t req_op  [N_REQ];
  len_t    req_len [N_REQ];
  tid_t    req_tid [N_REQ];
  logic    req_rd  [N_REQ];
  beat_t   beat_q  [MAX_BEATS];
  int      n_beats;

  // Progress counters, heads of the model queues
  int cycles;
  int acc_cnt;
  int sq_idx;
  int m_idx;
  int in_idx;
  int in_cnt;

  beat_t   exp_beat;
  opcode_t exp_op;
  len_t    exp_len;
  tid_t    exp_tid;
  logic    cur_rd;

  assign exp_beat = beat_q[m_idx];
  assign exp_op   = req_op[sq_idx];
  assign exp_len  = req_len[sq_idx];
  assign exp_tid  = req_tid[sq_idx];
  // Burst currently taken from the inputs
  assign cur_rd   = req_rd[in_idx];

  assign recv_tvalid     = src_valid[RECV];
  assign recv_tdata      = src_beat[RECV].data;
  assign recv_tkeep      = src_beat[RECV].keep;
  assign recv_tlast      = src_beat[RECV].last;
  assign recv_tid        = src_beat[RECV].tid;
  assign src_ready[RECV] = recv_tready;
  assign resp_tvalid     = src_valid[RESP];
  assign resp_tdata      = src_beat[RESP].data;
  assign resp_tkeep      = src_beat[RESP].keep;
  assign resp_tlast      = src_beat[RESP].last;
  assign resp_tid        = src_beat[RESP].tid;
  assign src_ready[RESP] = resp_tready;

  join_top #(
    .DATA_BITS  (DATA_BITS),
    .REQ_DEPTH  (4),
    .FIFO_DEPTH (16)
  ) DUT (
    .aclk        (aclk),        .aresetn     (aresetn),
    .rq_valid    (rq_valid),    .rq_ready    (rq_ready),
    .rq_opcode   (rq_opcode),   .rq_len      (rq_len),      .rq_tid    (rq_tid),
    .sq_valid    (sq_valid),    .sq_ready    (sq_ready),
    .sq_opcode   (sq_opcode),   .sq_len      (sq_len),      .sq_tid    (sq_tid),
    .recv_tvalid (recv_tvalid), .recv_tready (recv_tready), .recv_tdata (recv_tdata),
    .recv_tkeep  (recv_tkeep),  .recv_tlast  (recv_tlast),  .recv_tid   (recv_tid),
    .resp_tvalid (resp_tvalid), .resp_tready (resp_tready), .resp_tdata (resp_tdata),
    .resp_tkeep  (resp_tkeep),  .resp_tlast  (resp_tlast),  .resp_tid   (resp_tid),
    .m_tvalid    (m_tvalid),    .m_tready    (m_tready),    .m_tdata    (m_tdata),
    .m_tkeep     (m_tkeep),     .m_tlast     (m_tlast),     .m_tid      (m_tid)
  );

  initial aclk = 1'b0;
  always #50 aclk = ~aclk;

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------

  // Beat pattern from the per-stream counter
  function automatic beat_t make_beat(input int s, input int idx, input tid_t tid,
                                      input logic last);
    beat_t b;
    b.data = {(s == RESP) ? 16'hD5A0 : 16'hC3E0, 16'(idx), 32'(idx) * 32'h9E37_79B9};
    b.keep = 8'hFF >> ((idx + s) % 8);
    b.last = last;
    b.tid  = tid;
    return b;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
  endtask

  // One stream source, bursts sized from its own copy of the request order
  task automatic feed_stream(input int s);
    int   idx;
    logic took;
    idx = 0;
    wait (aresetn === 1'b1);
    @(posedge aclk);
    #1;
    for (int r = 0; r < N_REQ; r++) begin
      if (req_rd[r] == (s == RESP)) begin
        for (int k = 0; k <= int'(req_len[r]); k++) begin
          repeat ($urandom_range(0, 1)) begin
            @(posedge aclk);
            #1;
          end
          src_beat[s]  = make_beat(s, idx, req_tid[r], k == int'(req_len[r]));
          src_valid[s] = 1'b1;
          // Handshake sampled mid-cycle where inputs are settled
          do begin
            @(negedge aclk);
            took = src_ready[s];
            @(posedge aclk);
            #1;
          end while (!took);
          src_valid[s] = 1'b0;
          idx++;
        end
      end
    end
  endtask

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------

  initial feed_stream(RECV);
  initial feed_stream(RESP);

  initial begin : request_driver
    logic took;
    wait (aresetn === 1'b1);
    @(posedge aclk);
    #1;
    for (int r = 0; r < N_REQ; r++) begin
      repeat ($urandom_range(0, 2)) begin
        @(posedge aclk);
        #1;
      end
      rq_valid  = 1'b1;
      rq_opcode = req_op[r];
      rq_len    = req_len[r];
      rq_tid    = req_tid[r];
      do begin
        @(negedge aclk);
        took = rq_ready;
        @(posedge aclk);
        #1;
      end while (!took);
      rq_valid = 1'b0;
    end
  end

  // Random back-pressure on both outputs
  initial begin : ready_toggle
    wait (aresetn === 1'b1);
    forever begin
      @(posedge aclk);
      #1;
      m_tready = ($urandom_range(0, 3) != 0);
      sq_ready = ($urandom_range(0, 3) != 0);
    end
  end

  initial begin : main_seq
    int rc;
    int wc;
    void'($urandom(96138));
    aresetn   = 1'b0;
    rq_valid  = 1'b0;
    rq_opcode = '0;
    rq_len    = '0;
    rq_tid    = '0;
    sq_ready  = 1'b0;
    m_tready  = 1'b0;
    for (int s = 0; s < 2; s++) begin
      src_valid[s] = 1'b0;
      src_beat[s]  = '0;
    end
    // Requests, then the beats they pull in request order
    rc      = 0;
    wc      = 0;
    n_beats = 0;
    for (int r = 0; r < N_REQ; r++) begin
      req_op[r]  = opcode_t'($urandom_range(0, 3));
      req_len[r] = len_t'($urandom_range(0, MAX_LEN));
      req_tid[r] = tid_t'($urandom);
      req_rd[r]  = (req_op[r] == OP_RD) || (req_op[r] == OP_RD_ATOMIC);
      for (int k = 0; k <= int'(req_len[r]); k++) begin
        if (req_rd[r]) begin
          beat_q[n_beats] = make_beat(RESP, rc, req_tid[r], k == int'(req_len[r]));
          rc++;
        end else begin
          beat_q[n_beats] = make_beat(RECV, wc, req_tid[r], k == int'(req_len[r]));
          wc++;
        end
        n_beats++;
      end
    end
    repeat (8) @(posedge aclk);
    #1;
    assert (!sq_valid && !m_tvalid && !rq_ready && !recv_tready && !resp_tready)
      else report_mismatch("outputs not idle after reset");
    aresetn = 1'b1;
    while (!(m_idx == n_beats && sq_idx == N_REQ)) begin
      @(posedge aclk);
    end
    // Quiet tail, stray beats or requests trip the order checks
    repeat (10) @(posedge aclk);
    $display("*** PASSED ***");
    $finish;
  end

  // ------------------------------------------------------------------
  // Model tracking and checks
  // ------------------------------------------------------------------

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run("Timeout, not all beats and requests were seen within the cycle limit");
    end
  end

  always @(posedge aclk) begin
    if (!aresetn) begin
      acc_cnt <= 0;
      sq_idx  <= 0;
      m_idx   <= 0;
      in_idx  <= 0;
      in_cnt  <= 0;
    end else begin
      if (rq_valid && rq_ready) begin
        acc_cnt <= acc_cnt + 1;
      end
      if (sq_valid && sq_ready) begin
        sq_idx <= sq_idx + 1;
      end
      if (m_tvalid && m_tready) begin
        m_idx <= m_idx + 1;
      end
      // Input burst ends after len+1 beats
      if ((recv_tvalid && recv_tready) || (resp_tvalid && resp_tready)) begin
        if (in_cnt == int'(req_len[in_idx])) begin
          in_idx <= in_idx + 1;
          in_cnt <= 0;
        end else begin
          in_cnt <= in_cnt + 1;
        end
      end
    end
  end

  assert property (@(posedge aclk) disable iff (!aresetn)
    (sq_valid && sq_ready) |-> (sq_idx < acc_cnt && sq_opcode == exp_op &&
                                sq_len == exp_len && sq_tid == exp_tid))
    else report_mismatch("request on sq differs from accepted request order");

  assert property (@(posedge aclk) disable iff (!aresetn)
    (sq_valid && !sq_ready) |=> (sq_valid && $stable({sq_opcode, sq_len, sq_tid})))
    else report_mismatch("sq request changed while stalled");

  assert property (@(posedge aclk) disable iff (!aresetn)
    (m_tvalid && m_tready) |-> (m_idx < n_beats &&
                                {m_tdata, m_tkeep, m_tlast, m_tid} == exp_beat))
    else report_mismatch("output beat differs from model sequence");

  assert property (@(posedge aclk) disable iff (!aresetn)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable({m_tdata, m_tkeep, m_tlast, m_tid})))
    else report_mismatch("output beat changed while stalled");

  assert property (@(posedge aclk) disable iff (!aresetn) !(recv_tready && resp_tready))
    else report_mismatch("recv_tready and resp_tready high together");

  // Only the stream of the current request may be drained
  assert property (@(posedge aclk) disable iff (!aresetn)
    recv_tready |-> (in_idx < acc_cnt && !cur_rd))
    else report_mismatch("recv_tready high outside a write burst");

  assert property (@(posedge aclk) disable iff (!aresetn)
    resp_tready |-> (in_idx < acc_cnt && cur_rd))
    else report_mismatch("resp_tready high outside a read burst");

endmodule

// ==== join_top.f ====
join_pkg.sv
req_queue.sv
beat_fifo.sv
stream_join.sv
join_top.sv
tb_join_top.sv

// ==== Bender.yml ====
package:
  name: join_top

sources:
  # Package first, then leaf modules and the top level
  - join_pkg.sv
  - req_queue.sv
  - beat_fifo.sv
  - stream_join.sv
  - join_top.sv
  - target: test
    files:
      - tb_join_top.sv
